/* Makefile */
# Verilator flow for the rename unit testbench

TOP := rename_unit_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP)

# the log decides pass or fail
run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Verification passed$$" sim.log

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* dv/rename_unit_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_unit_assertions (
	input wire clock,
	input wire reset,
	input wire out_valid,
	input wire out_ready,
	input wire [rename_pkg::PHYS_W-1:0] out_dest_tag,
	input wire [rename_pkg::PHYS_W-1:0] out_src1_tag,
	input wire [rename_pkg::PHYS_W-1:0] out_src2_tag,
	input wire out_is_alu,
	input wire [rename_pkg::IMM_W-1:0] out_imm,
	input wire [rename_pkg::FL_CNT_W-1:0] free_count,
	input wire retire_valid,
	input wire retire_ready
);

	// number of failed checks, read by the testbench at the end
	int failures = 0;

	// a stalled output keeps its valid and its whole payload
	out_held_a: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_dest_tag)
			&& $stable(out_src1_tag) && $stable(out_src2_tag)
			&& $stable(out_is_alu) && $stable(out_imm))
	else begin
		failures++;
		$error("renamed output changed while stalled");
	end

	// the pool never holds more than the tags outside the reset map
	free_bound_a: assert property (@(posedge clock) disable iff (reset)
		free_count <= rename_pkg::FL_CNT_W'(rename_pkg::FL_SIZE))
	else begin
		failures++;
		$error("free_count above free list capacity");
	end

	// a retire request the queue cannot take returns no tag to the pool
	retire_gate_a: assert property (@(posedge clock) disable iff (reset)
		retire_valid && !retire_ready |=> free_count <= $past(free_count))
	else begin
		failures++;
		$error("retirement with retire_ready low");
	end

endmodule

`default_nettype wire

/* dv/rename_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_unit_tb;

	logic clock = 1'b0;
	logic reset;
	logic in_valid;
	wire in_ready;
	logic [31:0] in_word;
	wire out_valid;
	logic out_ready;
	wire [rename_pkg::PHYS_W-1:0] out_dest_tag;
	wire [rename_pkg::PHYS_W-1:0] out_src1_tag;
	wire [rename_pkg::PHYS_W-1:0] out_src2_tag;
	wire out_is_alu;
	wire [rename_pkg::IMM_W-1:0] out_imm;
	logic retire_valid;
	wire retire_ready;
	wire [rename_pkg::ARCH_W-1:0] retire_arch;
	wire [rename_pkg::PHYS_W-1:0] retire_tag;
	wire [rename_pkg::PHYS_W-1:0] retire_old_tag;
	wire [rename_pkg::FL_CNT_W-1:0] free_count;
	wire free_empty;

	integer seed;
	int errors;
	int n_accepted;
	int n_delivered;
	int n_retired;
	// dispatch stalled last cycle, so the word must stay put
	bit hold_input;

	// reference model
	logic [rename_pkg::PHYS_W-1:0] model_map [rename_pkg::NUM_ARCH_REG];
	logic [rename_pkg::PHYS_W-1:0] free_q [$];
	// renamed words accepted but not yet delivered
	logic [rename_pkg::PHYS_W-1:0] exp_dest [$];
	logic [rename_pkg::PHYS_W-1:0] exp_src1 [$];
	logic [rename_pkg::PHYS_W-1:0] exp_src2 [$];
	logic exp_alu [$];
	logic [rename_pkg::IMM_W-1:0] exp_imm [$];
	// retirements still owed, oldest first
	logic [rename_pkg::ARCH_W-1:0] ret_arch [$];
	logic [rename_pkg::PHYS_W-1:0] ret_tag [$];
	logic [rename_pkg::PHYS_W-1:0] ret_old [$];

	always #5 clock = ~clock;

	rename_unit dut_i (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_word(in_word),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_dest_tag(out_dest_tag),
		.out_src1_tag(out_src1_tag),
		.out_src2_tag(out_src2_tag),
		.out_is_alu(out_is_alu),
		.out_imm(out_imm),
		.retire_valid(retire_valid),
		.retire_ready(retire_ready),
		.retire_arch(retire_arch),
		.retire_tag(retire_tag),
		.retire_old_tag(retire_old_tag),
		.free_count(free_count),
		.free_empty(free_empty)
	);

	bind rename_unit rename_unit_assertions assertions_i (
		.clock(clock),
		.reset(reset),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_dest_tag(out_dest_tag),
		.out_src1_tag(out_src1_tag),
		.out_src2_tag(out_src2_tag),
		.out_is_alu(out_is_alu),
		.out_imm(out_imm),
		.free_count(free_count),
		.retire_valid(retire_valid),
		.retire_ready(retire_ready)
	);

	function automatic bit chance(input int pct);
		return ((($random(seed)) & 32'h7fff_ffff) % 100) < pct;
	endfunction

	// random alu or ldi word, built through the shared layout
	function automatic logic [31:0] make_word(input bit alu);
		rename_pkg::inst_word_u w;
		w = '0;
		if (alu) begin
			w.alu.opcode = rename_pkg::OP_ALU;
			w.alu.dest = rename_pkg::ARCH_W'($random(seed));
			w.alu.src1 = rename_pkg::ARCH_W'($random(seed));
			w.alu.src2 = rename_pkg::ARCH_W'($random(seed));
			w.alu.func = rename_pkg::FUNC_W'($random(seed));
		end else begin
			w.ldi.opcode = rename_pkg::OP_LDI;
			w.ldi.dest = rename_pkg::ARCH_W'($random(seed));
			w.ldi.imm = rename_pkg::IMM_W'($random(seed));
		end
		return w;
	endfunction

	task automatic report_mismatch(input string name, input int got, input int exp);
		errors++;
		$display("ERROR at %0t: %s = %0d, expected %0d", $time, name, got, exp);
	endtask

	// runs at the falling edge, sees what the next rising edge will transfer
	task automatic observe();
		rename_pkg::inst_word_u w;
		logic [rename_pkg::PHYS_W-1:0] new_tag;
		bit exp_ready;
		w = in_word;
		exp_ready = (free_q.size() != 0) && (ret_arch.size() != rename_pkg::ROB_DEPTH)
			&& (exp_dest.size() == 0 || out_ready);
		// status outputs against the model
		if (int'(free_count) != free_q.size())
			report_mismatch("free_count", int'(free_count), free_q.size());
		if (free_empty !== (free_q.size() == 0))
			report_mismatch("free_empty", int'(free_empty), int'(free_q.size() == 0));
		if (retire_ready !== (ret_arch.size() != 0))
			report_mismatch("retire_ready", int'(retire_ready), int'(ret_arch.size() != 0));
		if (out_valid !== (exp_dest.size() != 0))
			report_mismatch("out_valid", int'(out_valid), int'(exp_dest.size() != 0));
		if (in_ready !== exp_ready)
			report_mismatch("in_ready", int'(in_ready), int'(exp_ready));
		// delivery comes first, the output stage holds one word at most
		if (out_valid && out_ready) begin
			if (exp_dest.size() == 0) begin
				errors++;
				$display("renamed output delivered with nothing accepted in the model");
			end else begin
				if (n_delivered == 0 && int'(out_dest_tag) != rename_pkg::NUM_ARCH_REG)
					report_mismatch("out_dest_tag", int'(out_dest_tag),
						rename_pkg::NUM_ARCH_REG);
				if (out_dest_tag !== exp_dest[0])
					report_mismatch("out_dest_tag", int'(out_dest_tag), int'(exp_dest[0]));
				if (out_src1_tag !== exp_src1[0])
					report_mismatch("out_src1_tag", int'(out_src1_tag), int'(exp_src1[0]));
				if (out_src2_tag !== exp_src2[0])
					report_mismatch("out_src2_tag", int'(out_src2_tag), int'(exp_src2[0]));
				if (out_is_alu !== exp_alu[0])
					report_mismatch("out_is_alu", int'(out_is_alu), int'(exp_alu[0]));
				// the immediate only means something for ldi
				if (!exp_alu[0] && out_imm !== exp_imm[0])
					report_mismatch("out_imm", int'(out_imm), int'(exp_imm[0]));
				void'(exp_dest.pop_front());
				void'(exp_src1.pop_front());
				void'(exp_src2.pop_front());
				void'(exp_alu.pop_front());
				void'(exp_imm.pop_front());
			end
			// counted on the DUT handshake, so a duplicate shows at the end
			n_delivered++;
		end
		if (in_valid && in_ready) begin
			if (free_q.size() == 0) begin
				errors++;
				$display("dispatch accepted with no free tag left in the model");
			end else begin
				// dest takes the free head, sources read the map before the write
				new_tag = free_q.pop_front();
				exp_dest.push_back(new_tag);
				if (w.alu.opcode == rename_pkg::OP_ALU) begin
					exp_src1.push_back(model_map[w.alu.src1]);
					exp_src2.push_back(model_map[w.alu.src2]);
					exp_alu.push_back(1'b1);
				end else begin
					exp_src1.push_back('0);
					exp_src2.push_back('0);
					exp_alu.push_back(1'b0);
				end
				exp_imm.push_back(w.ldi.imm);
				ret_arch.push_back(w.alu.dest);
				ret_tag.push_back(new_tag);
				ret_old.push_back(model_map[w.alu.dest]);
				model_map[w.alu.dest] = new_tag;
				n_accepted++;
			end
		end
		if (retire_valid && retire_ready) begin
			if (ret_arch.size() == 0) begin
				errors++;
				$display("retirement with nothing left to retire in the model");
			end else begin
				if (retire_arch !== ret_arch[0])
					report_mismatch("retire_arch", int'(retire_arch), int'(ret_arch[0]));
				if (retire_tag !== ret_tag[0])
					report_mismatch("retire_tag", int'(retire_tag), int'(ret_tag[0]));
				if (retire_old_tag !== ret_old[0])
					report_mismatch("retire_old_tag", int'(retire_old_tag), int'(ret_old[0]));
				// old tag goes back behind whatever dispatch took this edge
				free_q.push_back(ret_old[0]);
				void'(ret_arch.pop_front());
				void'(ret_tag.pop_front());
				void'(ret_old.pop_front());
			end
			n_retired++;
		end
		hold_input = in_valid && !in_ready;
	endtask

	task automatic drive_cycle(input int in_pct, input int out_pct, input int ret_pct);
		@(posedge clock);
		#1;
		if (!hold_input) begin
			in_valid = chance(in_pct);
			in_word = make_word(chance(50));
		end
		out_ready = chance(out_pct);
		retire_valid = chance(ret_pct);
		@(negedge clock);
		observe();
	endtask

	initial begin
		int guard;
		int asrt_fail;
		seed = 31;
		reset = 1'b1;
		in_valid = 1'b0;
		in_word = '0;
		out_ready = 1'b0;
		retire_valid = 1'b0;
		hold_input = 1'b0;
		errors = 0;
		n_accepted = 0;
		n_delivered = 0;
		n_retired = 0;
		// identity map and the tags right above it in the pool
		for (int i = 0; i < rename_pkg::NUM_ARCH_REG; i++)
			model_map[i] = rename_pkg::PHYS_W'(i);
		for (int i = 0; i < rename_pkg::FL_SIZE; i++)
			free_q.push_back(rename_pkg::PHYS_W'(rename_pkg::NUM_ARCH_REG + i));
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		@(negedge clock);
		if (int'(free_count) != rename_pkg::FL_SIZE)
			report_mismatch("free_count", int'(free_count), rename_pkg::FL_SIZE);
		if (retire_ready !== 1'b0)
			report_mismatch("retire_ready", int'(retire_ready), 0);
		if (out_valid !== 1'b0)
			report_mismatch("out_valid", int'(out_valid), 0);

		// dispatch with no retirement until something fills
		guard = 0;
		while (free_q.size() != 0 && ret_arch.size() != rename_pkg::ROB_DEPTH
			&& guard < 200) begin
			drive_cycle(100, 70, 0);
			guard++;
		end
		if (free_q.size() != 0 && ret_arch.size() != rename_pkg::ROB_DEPTH) begin
			errors++;
			$display("timed out before the free list or retire queue filled up");
		end
		drive_cycle(100, 50, 0);
		if (in_ready !== 1'b0)
			report_mismatch("in_ready", int'(in_ready), 0);
		if (free_empty !== (free_q.size() == 0))
			report_mismatch("free_empty", int'(free_empty), int'(free_q.size() == 0));

		// mixed traffic, retirement slow and then fast
		for (int i = 0; i < 1500; i++)
			drive_cycle(70, 60, 35);
		for (int i = 0; i < 1500; i++)
			drive_cycle(50, 80, 70);

		// drain everything in flight
		guard = 0;
		while ((in_valid || exp_dest.size() != 0 || ret_arch.size() != 0) && guard < 300) begin
			drive_cycle(0, 100, 100);
			guard++;
		end
		if (in_valid || exp_dest.size() != 0 || ret_arch.size() != 0) begin
			errors++;
			$display("timed out draining the output stage and retire queue");
		end
		drive_cycle(0, 100, 0);
		if (int'(free_count) != rename_pkg::FL_SIZE)
			report_mismatch("free_count", int'(free_count), rename_pkg::FL_SIZE);
		if (n_delivered != n_accepted)
			report_mismatch("delivered count", n_delivered, n_accepted);
		if (n_retired != n_accepted)
			report_mismatch("retired count", n_retired, n_accepted);

		asrt_fail = dut_i.assertions_i.failures;
		$display("errors %0d, assertion failures %0d, accepted %0d, delivered %0d, retired %0d",
			errors, asrt_fail, n_accepted, n_delivered, n_retired);
		if (errors == 0 && asrt_fail == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/free_list.sv */
`timescale 1ns/1ps
`default_nettype none

module free_list (
	input wire clock,
	input wire reset,
	input wire pop,
	input wire push,
	input wire [rename_pkg::PHYS_W-1:0] push_tag,
	output logic [rename_pkg::PHYS_W-1:0] head_tag,
	output logic [rename_pkg::FL_CNT_W-1:0] count,
	output logic empty
);

	// slot 0 is the head, valid entries are 0 .. tail-1
	logic [rename_pkg::FL_SIZE-1:0][rename_pkg::PHYS_W-1:0] slots;
	logic [rename_pkg::FL_SIZE-1:0][rename_pkg::PHYS_W-1:0] next_slots;
	logic [rename_pkg::FL_SIZE-1:0][rename_pkg::PHYS_W-1:0] shifted;

	// tail doubles as the number of free tags
	logic [rename_pkg::FL_CNT_W-1:0] tail;
	logic [rename_pkg::FL_CNT_W-1:0] next_tail;
	logic [rename_pkg::FL_CNT_W-1:0] tail_dec;

	assign head_tag = slots[0];
	assign count = tail;
	assign empty = (tail == '0);

	// slot that was last valid before this edge
	assign tail_dec = tail - rename_pkg::FL_CNT_W'(1);

	// every entry moves one step toward the head
	always_comb begin
		for (int i = 0; i < rename_pkg::FL_SIZE - 1; i++) begin
			shifted[i] = slots[i + 1];
		end
		// last slot is beyond the tail after a pop, its content is don't care
		shifted[rename_pkg::FL_SIZE-1] = slots[rename_pkg::FL_SIZE-1];
	end

	// the top never pops when empty and never pushes when full,
	// since every tag lives in exactly one of map, queue and free list
	always_comb begin
		next_slots = slots;
		next_tail = tail;
		case ({pop, push})
			2'b11: begin
				// shift out the head and drop the returned tag in the
				// slot just vacated by the old tail
				next_slots = shifted;
				next_slots[tail_dec[rename_pkg::FL_IDX_W-1:0]] = push_tag;
			end
			2'b10: begin
				next_slots = shifted;
				next_tail = tail_dec;
			end
			2'b01: begin
				next_slots[tail[rename_pkg::FL_IDX_W-1:0]] = push_tag;
				next_tail = tail + rename_pkg::FL_CNT_W'(1);
			end
			default: begin
				// hold
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// tags 0..31 are taken by the identity map, so the
			// free pool starts right above them
			for (int i = 0; i < rename_pkg::FL_SIZE; i++) begin
				slots[i] <= rename_pkg::PHYS_W'(rename_pkg::NUM_ARCH_REG + i);
			end
			tail <= rename_pkg::FL_CNT_W'(rename_pkg::FL_SIZE);
		end else begin
			slots <= next_slots;
			tail <= next_tail;
		end
	end

endmodule

`default_nettype wire

/* hdl/map_table.sv */
`timescale 1ns/1ps
`default_nettype none

module map_table (
	input wire clock,
	input wire reset,
	input wire [rename_pkg::ARCH_W-1:0] rd1_arch,
	input wire [rename_pkg::ARCH_W-1:0] rd2_arch,
	input wire [rename_pkg::ARCH_W-1:0] wr_arch,
	input wire wr_en,
	input wire [rename_pkg::PHYS_W-1:0] wr_tag,
	output logic [rename_pkg::PHYS_W-1:0] rd1_tag,
	output logic [rename_pkg::PHYS_W-1:0] rd2_tag,
	output logic [rename_pkg::PHYS_W-1:0] old_tag
);

	// speculative mapping, one physical tag per architectural register
	logic [rename_pkg::PHYS_W-1:0] map [rename_pkg::NUM_ARCH_REG];

	// source lookups
	// combinational, so they show the mapping before this edge's write
	assign rd1_tag = map[rd1_arch];
	assign rd2_tag = map[rd2_arch];

	// mapping about to be replaced
	// freed later, when the instruction retires
	assign old_tag = map[wr_arch];

	always_ff @(posedge clock) begin
		if (reset) begin
			// identity: register i lives in tag i
			for (int i = 0; i < rename_pkg::NUM_ARCH_REG; i++) begin
				map[i] <= rename_pkg::PHYS_W'(i);
			end
		end else if (wr_en) begin
			map[wr_arch] <= wr_tag;
		end
	end

endmodule

`default_nettype wire

/* hdl/rename_pkg.sv */
`default_nettype none

package rename_pkg;

	// register file sizes
	localparam int NUM_ARCH_REG = 32;
	localparam int NUM_PHYS_REG = 64;

	// tags not holding an architectural mapping at reset
	localparam int FL_SIZE = NUM_PHYS_REG - NUM_ARCH_REG;

	// in-order retire queue entries
	localparam int ROB_DEPTH = 16;

	// index widths
	localparam int ARCH_W = $clog2(NUM_ARCH_REG);
	localparam int PHYS_W = $clog2(NUM_PHYS_REG);

	// free list slot index and occupancy (occupancy reaches FL_SIZE)
	localparam int FL_IDX_W = $clog2(FL_SIZE);
	localparam int FL_CNT_W = FL_IDX_W + 1;

	// retire queue pointer and occupancy
	localparam int RQ_IDX_W = $clog2(ROB_DEPTH);
	localparam int RQ_CNT_W = RQ_IDX_W + 1;

	// instruction word fields
	localparam int OP_W = 4;
	localparam int FUNC_W = 13;
	localparam int IMM_W = 23;

	// opcodes in bits 31:28
	localparam logic [OP_W-1:0] OP_ALU = 4'h1;
	localparam logic [OP_W-1:0] OP_LDI = 4'h2;

	// one 32-bit word, two layouts sharing the opcode position
	typedef union packed {
		struct packed {
			logic [OP_W-1:0] opcode;
			logic [ARCH_W-1:0] dest;
			logic [ARCH_W-1:0] src1;
			logic [ARCH_W-1:0] src2;
			logic [FUNC_W-1:0] func;
		} alu;
		struct packed {
			logic [OP_W-1:0] opcode;
			logic [ARCH_W-1:0] dest;
			logic [IMM_W-1:0] imm;
		} ldi;
	} inst_word_u;

endpackage

`default_nettype wire

/* hdl/rename_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_unit (
	input wire clock,
	input wire reset,

	// dispatch in
	input wire in_valid,
	output logic in_ready,
	input wire [31:0] in_word,

	// renamed instruction out
	output logic out_valid,
	input wire out_ready,
	output logic [rename_pkg::PHYS_W-1:0] out_dest_tag,
	output logic [rename_pkg::PHYS_W-1:0] out_src1_tag,
	output logic [rename_pkg::PHYS_W-1:0] out_src2_tag,
	output logic out_is_alu,
	output logic [rename_pkg::IMM_W-1:0] out_imm,

	// retirement
	input wire retire_valid,
	output logic retire_ready,
	output logic [rename_pkg::ARCH_W-1:0] retire_arch,
	output logic [rename_pkg::PHYS_W-1:0] retire_tag,
	output logic [rename_pkg::PHYS_W-1:0] retire_old_tag,

	// free pool status
	output logic [rename_pkg::FL_CNT_W-1:0] free_count,
	output logic free_empty
);

	// decoded view of the incoming word
	rename_pkg::inst_word_u word;
	logic is_alu;
	logic is_ldi;
	logic [rename_pkg::ARCH_W-1:0] dest_arch;

	// map and free list lookups for the incoming instruction
	logic [rename_pkg::PHYS_W-1:0] src1_tag;
	logic [rename_pkg::PHYS_W-1:0] src2_tag;
	logic [rename_pkg::PHYS_W-1:0] prev_tag;
	logic [rename_pkg::PHYS_W-1:0] new_tag;

	// retire queue status
	logic rq_full;
	logic rq_empty;

	// the two transfer events
	logic accepted;
	logic retired;

	assign word = in_word;
	assign is_alu = (word.alu.opcode == rename_pkg::OP_ALU);
	assign is_ldi = (word.ldi.opcode == rename_pkg::OP_LDI);

	// dest sits in the same bits in both layouts
	assign dest_arch = word.alu.dest;

	// a slot in the output stage opens when it is empty or draining now
	assign in_ready = !free_empty && !rq_full && (!out_valid || out_ready);
	assign accepted = in_valid && in_ready;

	assign retire_ready = !rq_empty;
	assign retired = retire_valid && retire_ready;

	free_list free_list_i (
		.clock(clock),
		.reset(reset),
		.pop(accepted),
		.push(retired),
		.push_tag(retire_old_tag),
		.head_tag(new_tag),
		.count(free_count),
		.empty(free_empty)
	);

	// sources read the mapping before the dest update on the same edge
	map_table map_table_i (
		.clock(clock),
		.reset(reset),
		.rd1_arch(word.alu.src1),
		.rd2_arch(word.alu.src2),
		.wr_arch(dest_arch),
		.wr_en(accepted),
		.wr_tag(new_tag),
		.rd1_tag(src1_tag),
		.rd2_tag(src2_tag),
		.old_tag(prev_tag)
	);

	// head entry drives the retire port directly
	retire_queue retire_queue_i (
		.clock(clock),
		.reset(reset),
		.push(accepted),
		.pop(retired),
		.push_arch(dest_arch),
		.push_tag(new_tag),
		.push_old_tag(prev_tag),
		.head_arch(retire_arch),
		.head_tag(retire_tag),
		.head_old_tag(retire_old_tag),
		.full(rq_full),
		.empty(rq_empty)
	);

	// output stage valid
	// a new accept overwrites a word leaving on the same edge
	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (accepted) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// output stage payload, loaded only on accept
	always_ff @(posedge clock) begin
		if (accepted) begin
			out_dest_tag <= new_tag;
			out_is_alu <= is_alu;
			// ldi has no register sources
			out_src1_tag <= is_alu ? src1_tag : '0;
			out_src2_tag <= is_alu ? src2_tag : '0;
			out_imm <= is_ldi ? word.ldi.imm : '0;
		end
	end

endmodule

`default_nettype wire

/* hdl/retire_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_queue (
	input wire clock,
	input wire reset,
	input wire push,
	input wire pop,
	input wire [rename_pkg::ARCH_W-1:0] push_arch,
	input wire [rename_pkg::PHYS_W-1:0] push_tag,
	input wire [rename_pkg::PHYS_W-1:0] push_old_tag,
	output logic [rename_pkg::ARCH_W-1:0] head_arch,
	output logic [rename_pkg::PHYS_W-1:0] head_tag,
	output logic [rename_pkg::PHYS_W-1:0] head_old_tag,
	output logic full,
	output logic empty
);

	// entry storage, one field per array
	logic [rename_pkg::ARCH_W-1:0] arch_mem [rename_pkg::ROB_DEPTH];
	logic [rename_pkg::PHYS_W-1:0] tag_mem [rename_pkg::ROB_DEPTH];
	logic [rename_pkg::PHYS_W-1:0] old_mem [rename_pkg::ROB_DEPTH];

	// depth is a power of two, so the pointers wrap on their own
	logic [rename_pkg::RQ_IDX_W-1:0] head;
	logic [rename_pkg::RQ_IDX_W-1:0] tail;

	// occupancy, needs one more bit than the pointers
	logic [rename_pkg::RQ_CNT_W-1:0] used;

	assign full = (used == rename_pkg::RQ_CNT_W'(rename_pkg::ROB_DEPTH));
	assign empty = (used == '0);

	// oldest entry is visible without waiting for a pop
	assign head_arch = arch_mem[head];
	assign head_tag = tag_mem[head];
	assign head_old_tag = old_mem[head];

	// payload write at the tail
	always_ff @(posedge clock) begin
		if (push) begin
			arch_mem[tail] <= push_arch;
			tag_mem[tail] <= push_tag;
			old_mem[tail] <= push_old_tag;
		end
	end

	// pointers move independently
	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
		end else begin
			if (push) begin
				tail <= tail + rename_pkg::RQ_IDX_W'(1);
			end
			if (pop) begin
				head <= head + rename_pkg::RQ_IDX_W'(1);
			end
		end
	end

	// occupancy
	// push with pop on one edge leaves it alone
	always_ff @(posedge clock) begin
		if (reset) begin
			used <= '0;
		end else begin
			case ({push, pop})
				2'b10: used <= used + rename_pkg::RQ_CNT_W'(1);
				2'b01: used <= used - rename_pkg::RQ_CNT_W'(1);
				default: used <= used;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src.f */
hdl/rename_pkg.sv
hdl/free_list.sv
hdl/map_table.sv
hdl/retire_queue.sv
hdl/rename_unit.sv
dv/rename_unit_assertions.sv
dv/rename_unit_tb.sv
